//--- capture/event_capture.sv
`timescale 1ns/1ps

module event_capture (
        input  logic                                    clk,
        input  logic                                    arst_n,
        input  logic [profiler_pkg::NUM_CHANNELS-1:0]   channel_idle,
        input  logic                                    cfg_enable,
        input  logic                                    cfg_mode,
        input  logic                                    cfg_clear,
        input  logic                                    wr_ready,
        output logic                                    wr_valid,
        output profiler_pkg::perf_entry_t               wr_entry
);

        // Free-running time base
        logic [profiler_pkg::TS_W-1:0]          ts_count;

        // Registered idle levels for edge detection
        logic [profiler_pkg::NUM_CHANNELS-1:0]  idle_prev;
        logic [profiler_pkg::NUM_CHANNELS-1:0]  idle_rise;
        logic [profiler_pkg::NUM_CHANNELS-1:0]  idle_fall;

        // Per-channel start of activity in elapsed mode
        logic [profiler_pkg::TS_W-1:0]          start_time [profiler_pkg::NUM_CHANNELS];

        // Chosen channel for this cycle
        logic [profiler_pkg::CHAN_W-1:0]        sel_chan;
        logic                                   sel_found;
        logic                                   elapsed_mode;

        assign elapsed_mode = (cfg_mode == profiler_pkg::MODE_ELAPSED);

        // ====================
        // Timestamp counter
        // ====================

        // Clear wins over counting
        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        ts_count <= '0;
                end else if (cfg_clear) begin
                        ts_count <= '0;
                end else if (cfg_enable) begin
                        ts_count <= ts_count + 1'b1;
                end
        end

        // ====================
        // Edge detection
        // ====================

        // All channels start out idle
        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        idle_prev <= '1;
                end else if (cfg_enable) begin
                        idle_prev <= channel_idle;
                end
        end

        // Rise is active to idle, fall is idle to active
        assign idle_rise = channel_idle & ~idle_prev;
        assign idle_fall = ~channel_idle & idle_prev;

        // ====================
        // Start times
        // ====================

        // Every channel that goes active stores the time base,
        // not only the one picked for the queue
        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        for (int i = 0; i < profiler_pkg::NUM_CHANNELS; i++) begin
                                start_time[i] <= '0;
                        end
                end else if (cfg_clear) begin
                        for (int i = 0; i < profiler_pkg::NUM_CHANNELS; i++) begin
                                start_time[i] <= '0;
                        end
                end else if (cfg_enable && elapsed_mode) begin
                        for (int i = 0; i < profiler_pkg::NUM_CHANNELS; i++) begin
                                if (idle_fall[i]) begin
                                        start_time[i] <= ts_count;
                                end
                        end
                end
        end

        // ====================
        // Channel choice
        // ====================

        // Scan from channel 0 up, first hit wins
        // Other channels with edges this cycle are not recorded
        always_comb begin
                sel_chan  = '0;
                sel_found = 1'b0;
                for (int i = 0; i < profiler_pkg::NUM_CHANNELS; i++) begin
                        // Elapsed mode only reports the return to idle
                        if (!sel_found && (idle_rise[i] || (idle_fall[i] && !elapsed_mode))) begin
                                sel_chan  = profiler_pkg::CHAN_W'(i);
                                sel_found = 1'b1;
                        end
                end
        end

        // ====================
        // Entry building
        // ====================

        always_comb begin
                wr_entry.channel = sel_chan;
                if (elapsed_mode) begin
                        // Duration in enabled cycles
                        wr_entry.event_type = profiler_pkg::EVENT_END;
                        wr_entry.value      = ts_count - start_time[sel_chan];
                end else begin
                        wr_entry.event_type = idle_rise[sel_chan] ? profiler_pkg::EVENT_END
                                                                  : profiler_pkg::EVENT_START;
                        wr_entry.value      = ts_count;
                end
        end

        // No room in the queue means the event is lost
        assign wr_valid = cfg_enable && sel_found && wr_ready;

endmodule

//--- common/event_fifo_if.sv
`timescale 1ns/1ps

interface event_fifo_if;

        // Head of queue
        profiler_pkg::perf_entry_t          rd_entry;

        // Head entry is present
        logic                               rd_valid;

        // Queue status
        logic                               full;
        logic [profiler_pkg::CNT_W-1:0]     count;

        // One-cycle pop while rd_valid is high
        logic                               pop;

        // Queue drives data and status
        modport fifo_side (
                output rd_entry,
                output rd_valid,
                output full,
                output count,
                input  pop
        );

        // Readout pops and takes data
        modport reader_side (
                input  rd_entry,
                input  rd_valid,
                input  full,
                input  count,
                output pop
        );

endinterface

//--- common/profiler_pkg.sv
package profiler_pkg;

        // ====================
        // Sizes
        // ====================

        // Profiled channels with one bit each in the idle mask
        localparam int NUM_CHANNELS = 8;

        // Channel number width
        localparam int CHAN_W = 3;

        // Timestamp and duration width
        localparam int TS_W = 32;

        // Event queue depth
        localparam int FIFO_DEPTH = 16;

        // Occupancy width that holds 0 to FIFO_DEPTH
        localparam int CNT_W = 5;

        // ====================
        // Encodings
        // ====================

        // Profiling mode
        typedef enum logic {
                MODE_TIMESTAMP = 1'b0,
                MODE_ELAPSED   = 1'b1
        } perf_mode_e;

        // Event kind
        // START is idle to active, END is active to idle
        typedef enum logic {
                EVENT_START = 1'b0,
                EVENT_END   = 1'b1
        } perf_event_e;

        // Queue entry of 36 bits
        // Value is a timestamp or a duration depending on mode
        typedef struct packed {
                perf_event_e             event_type;
                logic [CHAN_W-1:0]       channel;
                logic [TS_W-1:0]         value;
        } perf_entry_t;

endpackage

//--- dv/perf_checker.sv
`timescale 1ns/1ps

module perf_checker (
        input  logic                                    clk,
        input  logic                                    arst_n,
        input  logic [profiler_pkg::NUM_CHANNELS-1:0]   channel_idle,
        input  logic                                    cfg_enable,
        input  logic                                    cfg_mode,
        input  logic                                    cfg_clear,
        input  logic                                    perf_fifo_rd,
        input  logic [profiler_pkg::TS_W-1:0]           perf_fifo_data_low,
        input  logic [profiler_pkg::TS_W-1:0]           perf_fifo_data_high,
        input  logic                                    perf_fifo_empty,
        input  logic                                    perf_fifo_full,
        input  logic [profiler_pkg::CNT_W-1:0]          perf_fifo_count,
        output int                                      data_errors,
        output int                                      status_errors
);

        // Reference time base, idle history and start times
        logic [profiler_pkg::TS_W-1:0]          ts;
        logic [profiler_pkg::NUM_CHANNELS-1:0]  prev;
        logic [profiler_pkg::TS_W-1:0]          start [profiler_pkg::NUM_CHANNELS];

        // Expected queue and the entry the readout should hold
        profiler_pkg::perf_entry_t              model_q [$];
        profiler_pkg::perf_entry_t              held;

        always @(posedge clk) begin : model
                logic [profiler_pkg::NUM_CHANNELS-1:0]  rise;
                logic [profiler_pkg::NUM_CHANNELS-1:0]  fall;
                logic [profiler_pkg::TS_W-1:0]          exp_high;
                logic                                   exp_empty;
                logic                                   exp_full;
                logic                                   found;
                logic                                   room;
                logic                                   elapsed;
                profiler_pkg::perf_entry_t              ent;
                if (!arst_n) begin
                        ts = '0;
                        prev = '1;
                        start = '{default: '0};
                        model_q.delete();
                        held = '0;
                end else begin
                        // ====================
                        // Compare the state before this edge
                        // ====================
                        exp_empty = (model_q.size() == 0);
                        exp_full = (model_q.size() == profiler_pkg::FIFO_DEPTH);
                        if (perf_fifo_count !== profiler_pkg::CNT_W'(model_q.size())
                            || perf_fifo_empty !== exp_empty
                            || perf_fifo_full !== exp_full) begin
                                status_errors++;
                                $display("ERROR at %0t: count %0d empty %b full %b expected %0d",
                                         $time, perf_fifo_count, perf_fifo_empty, perf_fifo_full,
                                         model_q.size());
                        end
                        // Channel in bits 2..0, type in bit 3
                        exp_high = '0;
                        exp_high[2:0] = held.channel;
                        exp_high[3] = held.event_type;
                        if (perf_fifo_data_low !== held.value
                            || perf_fifo_data_high !== exp_high) begin
                                data_errors++;
                                $display("ERROR at %0t: data %h/%h, expected %h/%h", $time,
                                         perf_fifo_data_high, perf_fifo_data_low,
                                         exp_high, held.value);
                        end
                        // ====================
                        // Expected event this cycle
                        // ====================
                        elapsed = (cfg_mode == profiler_pkg::MODE_ELAPSED);
                        rise = channel_idle & ~prev;
                        fall = ~channel_idle & prev;
                        found = 1'b0;
                        ent = '0;
                        // Only the lowest channel is kept and the rest are lost
                        for (int i = 0; i < profiler_pkg::NUM_CHANNELS; i++) begin
                                if (!found && (rise[i] || (fall[i] && !elapsed))) begin
                                        found = 1'b1;
                                        ent.channel = profiler_pkg::CHAN_W'(i);
                                        ent.event_type = rise[i] ? profiler_pkg::EVENT_END
                                                                 : profiler_pkg::EVENT_START;
                                        ent.value = elapsed ? ts - start[i] : ts;
                                end
                        end
                        // Full queue drops the new event even with a pop
                        room = model_q.size() < profiler_pkg::FIFO_DEPTH;
                        if (cfg_clear) begin
                                ts = '0;
                                start = '{default: '0};
                                model_q.delete();
                                held = '0;
                        end else begin
                                for (int i = 0; i < profiler_pkg::NUM_CHANNELS; i++) begin
                                        if (cfg_enable && elapsed && fall[i]) begin
                                                start[i] = ts;
                                        end
                                end
                                if (perf_fifo_rd && model_q.size() != 0) begin
                                        held = model_q.pop_front();
                                end
                                if (cfg_enable && found && room) begin
                                        model_q.push_back(ent);
                                end
                                if (cfg_enable) begin
                                        ts = ts + 1;
                                end
                        end
                        if (cfg_enable) begin
                                prev = channel_idle;
                        end
                end
        end

endmodule

//--- dv/perf_profiler_sva.sv
`timescale 1ns/1ps

module perf_profiler_sva (
        input logic                             clk,
        input logic                             arst_n,
        input logic                             perf_fifo_empty,
        input logic                             perf_fifo_full,
        input logic [profiler_pkg::CNT_W-1:0]   perf_fifo_count
);

        // Status flags never contradict
        a_full_empty: assert property (@(posedge clk) disable iff (!arst_n)
                !(perf_fifo_full && perf_fifo_empty))
                else $error("Queue reports full and empty together");

        // Occupancy bounded by depth
        a_count_max: assert property (@(posedge clk) disable iff (!arst_n)
                perf_fifo_count <= profiler_pkg::CNT_W'(profiler_pkg::FIFO_DEPTH))
                else $error("Queue count above depth: %0d", perf_fifo_count);

        // Empty flag tracks a zero count
        a_empty_count: assert property (@(posedge clk) disable iff (!arst_n)
                perf_fifo_empty == (perf_fifo_count == '0))
                else $error("Empty flag disagrees with count %0d", perf_fifo_count);

endmodule

// Attached to every profiler top
bind perf_profiler_top perf_profiler_sva u_sva (
        .clk             (clk),
        .arst_n          (arst_n),
        .perf_fifo_empty (perf_fifo_empty),
        .perf_fifo_full  (perf_fifo_full),
        .perf_fifo_count (perf_fifo_count)
);

//--- dv/tb_perf_profiler.sv
`timescale 1ns/1ps

module tb_perf_profiler;

        localparam int          CLK_PERIOD    = 4;
        localparam int          RESET_CYCLES  = 5;
        localparam int          NUM_ROWS      = 7;
        localparam int          FILL_PULSES   = 10;
        localparam int          MARGIN_CYCLES = 120;
        localparam logic [31:0] LFSR_SEED     = 32'h8573;

        // Mode, channel mask, active cycles, read after one pulse
        typedef struct packed {
                logic           mode;
                logic [7:0]     mask;
                logic [7:0]     len;
                logic           read_after;
        } row_t;

        logic                                   clk;
        logic                                   arst_n;
        logic [profiler_pkg::NUM_CHANNELS-1:0]  channel_idle;
        logic                                   cfg_enable;
        logic                                   cfg_mode;
        logic                                   cfg_clear;
        logic                                   perf_fifo_rd;
        logic [profiler_pkg::TS_W-1:0]          perf_fifo_data_low;
        logic [profiler_pkg::TS_W-1:0]          perf_fifo_data_high;
        logic                                   perf_fifo_empty;
        logic                                   perf_fifo_full;
        logic [profiler_pkg::CNT_W-1:0]         perf_fifo_count;
        int                                     data_errors;
        int                                     status_errors;

        perf_profiler_top dut (.*);
        perf_checker chk (.*);

        // ====================
        // Stimulus table
        // ====================

        // Fill rows pulse FILL_PULSES times before the drain
        function automatic row_t stim_row(input int idx);
                case (idx)
                        0:       return '{1'b0, 8'h01, 8'd5, 1'b1};
                        1:       return '{1'b1, 8'h04, 8'd7, 1'b1};
                        2:       return '{1'b0, 8'h16, 8'd3, 1'b1};
                        3:       return '{1'b1, 8'hc8, 8'd4, 1'b1};
                        4:       return '{1'b0, 8'h80, 8'd2, 1'b0};
                        5:       return '{1'b1, 8'h02, 8'd9, 1'b1};
                        default: return '{1'b1, 8'h20, 8'd1, 1'b0};
                endcase
        endfunction

        // Galois LFSR stepped once per bit taken
        function automatic logic [31:0] lfsr_next(input logic [31:0] state);
                if (state[0]) begin
                        return (state >> 1) ^ 32'h8020_0003;
                end
                return state >> 1;
        endfunction

        // Channels in mask go active for len cycles
        task automatic pulse_channels(input logic [7:0] mask, input int len);
                @(posedge clk);
                channel_idle <= ~mask;
                repeat (len) @(posedge clk);
                channel_idle <= '1;
                @(posedge clk);
        endtask

        // One-cycle strobes until the queue is empty
        task automatic drain_queue();
                @(negedge clk);
                while (!perf_fifo_empty) begin
                        @(posedge clk);
                        perf_fifo_rd <= 1'b1;
                        @(posedge clk);
                        perf_fifo_rd <= 1'b0;
                        @(negedge clk);
                end
        endtask

        initial begin
                clk = 1'b0;
                forever begin
                        #(CLK_PERIOD / 2) clk = ~clk;
                end
        end

        // Limit from table length, pauses and drains
        initial begin : watchdog
                int unsigned    limit;
                row_t           row;
                limit = RESET_CYCLES + MARGIN_CYCLES;
                for (int r = 0; r < NUM_ROWS; r++) begin
                        row = stim_row(r);
                        limit += (row.read_after ? 1 : FILL_PULSES) * (row.len + 2)
                                 + 17 + 2 * profiler_pkg::FIFO_DEPTH;
                end
                #(limit * CLK_PERIOD);
                $display("Timeout: the run did not finish within %0d cycles", limit);
                $display("SIMULATION FAILED");
                $finish;
        end

        initial begin : stimulus
                row_t           row;
                logic [31:0]    lfsr;
                logic [3:0]     pause;
                arst_n <= 1'b0;
                channel_idle <= '1;
                cfg_enable <= 1'b0;
                cfg_mode <= 1'b0;
                cfg_clear <= 1'b0;
                perf_fifo_rd <= 1'b0;
                lfsr = LFSR_SEED;
                repeat (RESET_CYCLES) @(posedge clk);
                arst_n <= 1'b1;
                @(posedge clk);
                cfg_enable <= 1'b1;
                for (int r = 0; r < NUM_ROWS; r++) begin
                        row = stim_row(r);
                        for (int b = 0; b < 4; b++) begin
                                pause = {pause[2:0], lfsr[0]};
                                lfsr = lfsr_next(lfsr);
                        end
                        @(posedge clk);
                        cfg_mode <= row.mode;
                        repeat (pause) @(posedge clk);
                        repeat (row.read_after ? 1 : FILL_PULSES) pulse_channels(row.mask, row.len);
                        drain_queue();
                end
                // ====================
                // Clear and disable
                // ====================
                @(posedge clk);
                cfg_mode <= 1'b0;
                pulse_channels(8'h01, 3);
                @(posedge clk);
                perf_fifo_rd <= 1'b1;
                @(posedge clk);
                perf_fifo_rd <= 1'b0;
                cfg_clear <= 1'b1;
                @(posedge clk);
                cfg_clear <= 1'b0;
                cfg_enable <= 1'b0;
                // Nothing may be queued while disabled
                pulse_channels(8'h08, 4);
                @(posedge clk);
                cfg_enable <= 1'b1;
                repeat (4) @(posedge clk);
                $display("Check summary: %0d data errors, %0d status errors",
                         data_errors, status_errors);
                if (data_errors == 0 && status_errors == 0) begin
                        $display("SIMULATION PASSED");
                end else begin
                        $display("SIMULATION FAILED");
                end
                $finish;
        end

endmodule

//--- hdl/event_fifo.sv
`timescale 1ns/1ps

module event_fifo (
        input  logic                            clk,
        input  logic                            arst_n,
        input  logic                            cfg_clear,
        input  logic                            wr_valid,
        input  profiler_pkg::perf_entry_t       wr_entry,
        output logic                            wr_ready,
        event_fifo_if.fifo_side                 rd
);

        // Entry storage
        profiler_pkg::perf_entry_t      mem [profiler_pkg::FIFO_DEPTH];

        // Pointers wrap naturally at the power-of-two depth
        logic [$clog2(profiler_pkg::FIFO_DEPTH)-1:0]    wr_ptr;
        logic [$clog2(profiler_pkg::FIFO_DEPTH)-1:0]    rd_ptr;

        // Occupancy
        logic [profiler_pkg::CNT_W-1:0] count;

        // Accepted transfers
        logic                           wr_en;
        logic                           rd_en;
        logic                           is_full;
        logic                           is_empty;

        assign is_full  = (count == profiler_pkg::CNT_W'(profiler_pkg::FIFO_DEPTH));
        assign is_empty = (count == '0);

        assign wr_en = wr_valid && !is_full;
        assign rd_en = rd.pop && !is_empty;

        // ====================
        // Storage write
        // ====================

        always_ff @(posedge clk) begin
                if (wr_en) begin
                        mem[wr_ptr] <= wr_entry;
                end
        end

        // ====================
        // Pointers and count
        // ====================

        // Clear drops everything held
        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                        count  <= '0;
                end else if (cfg_clear) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                        count  <= '0;
                end else begin
                        if (wr_en) begin
                                wr_ptr <= wr_ptr + 1'b1;
                        end
                        if (rd_en) begin
                                rd_ptr <= rd_ptr + 1'b1;
                        end
                        // Push and pop together leave the count alone
                        case ({wr_en, rd_en})
                                2'b10:   count <= count + 1'b1;
                                2'b01:   count <= count - 1'b1;
                                default: count <= count;
                        endcase
                end
        end

        // ====================
        // Outputs
        // ====================

        assign wr_ready    = !is_full;
        assign rd.rd_entry = mem[rd_ptr];
        assign rd.rd_valid = !is_empty;
        assign rd.full     = is_full;
        assign rd.count    = count;

endmodule

//--- hdl/perf_profiler_top.sv
`timescale 1ns/1ps

module perf_profiler_top (
        input  logic                                    clk,
        input  logic                                    arst_n,
        input  logic [profiler_pkg::NUM_CHANNELS-1:0]   channel_idle,
        input  logic                                    cfg_enable,
        input  logic                                    cfg_mode,
        input  logic                                    cfg_clear,
        input  logic                                    perf_fifo_rd,
        output logic [profiler_pkg::TS_W-1:0]           perf_fifo_data_low,
        output logic [profiler_pkg::TS_W-1:0]           perf_fifo_data_high,
        output logic                                    perf_fifo_empty,
        output logic                                    perf_fifo_full,
        output logic [profiler_pkg::CNT_W-1:0]          perf_fifo_count
);

        // ====================
        // Capture to queue
        // ====================

        logic                           wr_valid;
        logic                           wr_ready;
        profiler_pkg::perf_entry_t      wr_entry;

        // Queue to readout
        event_fifo_if fifo_if ();

        // Edge capture and entry building
        event_capture u_capture (
                .clk            (clk),
                .arst_n         (arst_n),
                .channel_idle   (channel_idle),
                .cfg_enable     (cfg_enable),
                .cfg_mode       (cfg_mode),
                .cfg_clear      (cfg_clear),
                .wr_ready       (wr_ready),
                .wr_valid       (wr_valid),
                .wr_entry       (wr_entry)
        );

        // Event queue that drops while full
        event_fifo u_fifo (
                .clk            (clk),
                .arst_n         (arst_n),
                .cfg_clear      (cfg_clear),
                .wr_valid       (wr_valid),
                .wr_entry       (wr_entry),
                .wr_ready       (wr_ready),
                .rd             (fifo_if.fifo_side)
        );

        // Pop strobe and two-word readback
        perf_readout u_readout (
                .clk                    (clk),
                .arst_n                 (arst_n),
                .cfg_clear              (cfg_clear),
                .perf_fifo_rd           (perf_fifo_rd),
                .fifo                   (fifo_if.reader_side),
                .perf_fifo_data_low     (perf_fifo_data_low),
                .perf_fifo_data_high    (perf_fifo_data_high),
                .perf_fifo_empty        (perf_fifo_empty),
                .perf_fifo_full         (perf_fifo_full),
                .perf_fifo_count        (perf_fifo_count)
        );

endmodule

//--- hdl/perf_readout.sv
`timescale 1ns/1ps

module perf_readout (
        input  logic                            clk,
        input  logic                            arst_n,
        input  logic                            cfg_clear,
        input  logic                            perf_fifo_rd,
        event_fifo_if.reader_side               fifo,
        output logic [profiler_pkg::TS_W-1:0]   perf_fifo_data_low,
        output logic [profiler_pkg::TS_W-1:0]   perf_fifo_data_high,
        output logic                            perf_fifo_empty,
        output logic                            perf_fifo_full,
        output logic [profiler_pkg::CNT_W-1:0]  perf_fifo_count
);

        // Entry held between pops
        profiler_pkg::perf_entry_t      held;

        // Strobe on an empty queue does nothing
        assign fifo.pop = perf_fifo_rd && fifo.rd_valid;

        // Latch the head on the pop edge
        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        held <= '0;
                end else if (cfg_clear) begin
                        held <= '0;
                end else if (fifo.pop) begin
                        held <= fifo.rd_entry;
                end
        end

        // ====================
        // Word split
        // ====================

        // Low word carries timestamp or duration
        assign perf_fifo_data_low = held.value;

        // High word holds event type over channel with zeros above bit 3
        assign perf_fifo_data_high = {{(profiler_pkg::TS_W - 1 - profiler_pkg::CHAN_W){1'b0}},
                                      held.event_type, held.channel};

        // Status straight from the queue
        assign perf_fifo_empty = !fifo.rd_valid;
        assign perf_fifo_full  = fifo.full;
        assign perf_fifo_count = fifo.count;

endmodule

//--- perf_profiler.f
common/profiler_pkg.sv
common/event_fifo_if.sv
capture/event_capture.sv
hdl/event_fifo.sv
hdl/perf_readout.sv
hdl/perf_profiler_top.sv
dv/perf_profiler_sva.sv
dv/perf_checker.sv
dv/tb_perf_profiler.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, then grade the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_perf_profiler \
        -f perf_profiler.f -Mdir obj_dir -o sim_perf_profiler \
        && ./obj_dir/sim_perf_profiler > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "SIMULATION PASSED" sim.log && exit 0 || exit 1
